// File: rtl/pid_dispatch_config.svh
`ifndef PID_DISPATCH_CONFIG_SVH
`define PID_DISPATCH_CONFIG_SVH

// --------------------------------------------------
// Datapath widths
// --------------------------------------------------
// ADC source number width
`define PD_W_SRC 5
// Sample value width
`define PD_W_DATA 18

// Output channels of the PID controller
`define PD_N_CHAN 8
`define PD_W_CHAN 3

// --------------------------------------------------
// Buffering and flow control
// --------------------------------------------------
// Input FIFO depth, must be a power of two
`define PD_FIFO_DEPTH 16
// Downstream credits after reset
`define PD_OUT_CREDITS 4

// --------------------------------------------------
// Configuration register map
// --------------------------------------------------
`define PD_W_CFG_ADDR 4
// Route select of the addressed channel
`define PD_CFG_SRC_SEL 4'h1
// Enable bit of the addressed channel
`define PD_CFG_EN 4'h2

`endif

// File: rtl/pid_dispatch_pkg.sv
`default_nettype none

`include "pid_dispatch_config.svh"

package pid_dispatch_pkg;

   // --------------------------------------------------
   // Vector types
   // --------------------------------------------------
   // ADC source number
   typedef logic [`PD_W_SRC-1:0] src_t;
   // Routing select, top bit set means unrouted
   typedef logic [`PD_W_SRC:0] route_t;
   // Output channel number
   typedef logic [`PD_W_CHAN-1:0] chan_t;
   // Sample value
   typedef logic [`PD_W_DATA-1:0] adc_data_t;
   // Config register selector
   typedef logic [`PD_W_CFG_ADDR-1:0] cfg_addr_t;

   // --------------------------------------------------
   // Bundles
   // --------------------------------------------------
   // Tagged ADC sample
   typedef struct packed {
      src_t src;
      adc_data_t data;
   } sample_t;

   // Instruction toward the PID pipeline
   typedef struct packed {
      chan_t chan;
      adc_data_t data;
   } instr_t;

   // Routing table write, value holds a route or the enable in bit 0
   typedef struct packed {
      logic en;
      cfg_addr_t addr;
      chan_t chan;
      route_t value;
   } cfg_wr_t;

   // Dispatcher FSM
   typedef enum logic [1:0] {
      IDLE,
      SCAN,
      ADVANCE
   } dispatch_state_e;

endpackage

`default_nettype wire

// File: rtl/sample_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "pid_dispatch_config.svh"

module sample_fifo (
   input wire logic clk_in,
   input wire logic reset,
   input wire logic wr_valid,
   input wire pid_dispatch_pkg::sample_t wr_sample,
   input wire logic pop,
   output pid_dispatch_pkg::sample_t head,
   output logic head_valid,
   output logic credit
);

   import pid_dispatch_pkg::*;

   localparam int W_PTR = $clog2(`PD_FIFO_DEPTH);

   // --------------------------------------------------
   // Storage and pointers
   // --------------------------------------------------
   sample_t mem [`PD_FIFO_DEPTH];
   logic [W_PTR-1:0] wr_ptr;
   logic [W_PTR-1:0] rd_ptr;
   // One extra bit so a full buffer is distinct from empty
   logic [W_PTR:0] count;

   logic full;
   logic do_write;
   logic do_pop;

   assign full = (count == (W_PTR+1)'(`PD_FIFO_DEPTH));
   // Writes into a full buffer are dropped
   assign do_write = wr_valid && !full;
   assign do_pop = pop && head_valid;

   // Sample payload storage
   always_ff @(posedge clk_in) begin
      if (do_write) begin
         mem[wr_ptr] <= wr_sample;
      end
   end

   // Pointer and occupancy tracking
   always_ff @(posedge clk_in) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         // Pointers wrap on their own, depth is a power of two
         if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_write, do_pop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // --------------------------------------------------
   // Head and credit return
   // --------------------------------------------------
   // Oldest entry, valid one cycle after a write into the empty buffer
   assign head = mem[rd_ptr];
   assign head_valid = (count != '0);

   // One credit per popped sample, the slot is free from this edge on
   assign credit = do_pop;

endmodule

`default_nettype wire

// File: rtl/route_table.sv
`timescale 1ns/100ps
`default_nettype none

`include "pid_dispatch_config.svh"

module route_table (
   input wire logic clk_in,
   input wire logic reset,
   input wire pid_dispatch_pkg::cfg_wr_t cfg,
   output pid_dispatch_pkg::route_t [`PD_N_CHAN-1:0] src_sel,
   output logic [`PD_N_CHAN-1:0] chan_en
);

   import pid_dispatch_pkg::*;

   // Route with only the top bit set, matches no source
   localparam route_t ROUTE_NONE = route_t'(1 << `PD_W_SRC);

   // --------------------------------------------------
   // Address decode
   // --------------------------------------------------
   logic wr_src_sel;
   logic wr_en_bit;

   always_comb begin
      wr_src_sel = 1'b0;
      wr_en_bit = 1'b0;
      if (cfg.en) begin
         case (cfg.addr)
            `PD_CFG_SRC_SEL: wr_src_sel = 1'b1;
            `PD_CFG_EN: wr_en_bit = 1'b1;
            // Unknown addresses are dropped
            default: begin
               wr_src_sel = 1'b0;
               wr_en_bit = 1'b0;
            end
         endcase
      end
   end

   // --------------------------------------------------
   // Per-channel storage
   // --------------------------------------------------
   // Source select, full 6-bit value so a write can unroute a channel
   always_ff @(posedge clk_in) begin
      if (reset) begin
         for (int ch = 0; ch < `PD_N_CHAN; ch++) begin
            src_sel[ch] <= ROUTE_NONE;
         end
      end else if (wr_src_sel) begin
         src_sel[cfg.chan] <= cfg.value;
      end
   end

   // Enable bits, only bit 0 of the value is used
   always_ff @(posedge clk_in) begin
      if (reset) begin
         chan_en <= '0;
      end else if (wr_en_bit) begin
         chan_en[cfg.chan] <= cfg.value[0];
      end
   end

endmodule

`default_nettype wire

// File: rtl/instr_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

`include "pid_dispatch_config.svh"

module instr_dispatch (
   input wire logic clk_in,
   input wire logic reset,
   input wire pid_dispatch_pkg::sample_t head,
   input wire logic head_valid,
   input wire pid_dispatch_pkg::route_t [`PD_N_CHAN-1:0] src_sel,
   input wire logic [`PD_N_CHAN-1:0] chan_en,
   input wire logic can_send,
   output logic pop,
   output logic issue,
   output pid_dispatch_pkg::instr_t issue_instr
);

   import pid_dispatch_pkg::*;

   // --------------------------------------------------
   // State
   // --------------------------------------------------
   dispatch_state_e state;
   // Channels already handled for the current head sample
   logic [`PD_N_CHAN-1:0] sent;

   // Head source in route form, top bit clear
   route_t head_route;
   logic hit_found;
   chan_t hit_chan;
   logic hit_enabled;

   assign head_route = {1'b0, head.src};

   // Priority search over unsent channels
   // Walks downward so the lowest matching channel wins
   always_comb begin
      hit_found = 1'b0;
      hit_chan = '0;
      for (int ch = `PD_N_CHAN-1; ch >= 0; ch--) begin
         if (!sent[ch] && (src_sel[ch] == head_route)) begin
            hit_found = 1'b1;
            hit_chan = chan_t'(ch);
         end
      end
   end

   assign hit_enabled = chan_en[hit_chan];

   // --------------------------------------------------
   // Scan FSM
   // --------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (reset) begin
         state <= IDLE;
         sent <= '0;
      end else begin
         case (state)
            // Wait for a sample at the FIFO head
            IDLE: begin
               if (head_valid) begin
                  state <= SCAN;
               end
            end
            SCAN: begin
               if (!hit_found) begin
                  state <= ADVANCE;
               end else if (!hit_enabled || can_send) begin
                  // Disabled match costs one step and emits nothing
                  sent[hit_chan] <= 1'b1;
               end
               // Enabled match without credit holds here, mask untouched
            end
            // Release the sample and start over with a clean mask
            ADVANCE: begin
               sent <= '0;
               state <= IDLE;
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // --------------------------------------------------
   // Outputs
   // --------------------------------------------------
   // Pop lasts exactly the one ADVANCE cycle
   assign pop = (state == ADVANCE);

   // Instruction goes out only for an enabled match with a credit in hand
   assign issue = (state == SCAN) && hit_found && hit_enabled && can_send;
   assign issue_instr.chan = hit_chan;
   assign issue_instr.data = head.data;

endmodule

`default_nettype wire

// File: rtl/instr_credit_out.sv
`timescale 1ns/100ps
`default_nettype none

`include "pid_dispatch_config.svh"

module instr_credit_out (
   input wire logic clk_in,
   input wire logic reset,
   input wire logic issue,
   input wire pid_dispatch_pkg::instr_t issue_instr,
   input wire logic instr_credit,
   output logic can_send,
   output logic instr_valid,
   output pid_dispatch_pkg::instr_t instr
);

   localparam int W_CRED = $clog2(`PD_OUT_CREDITS + 1);
   localparam logic [W_CRED-1:0] CRED_MAX = W_CRED'(`PD_OUT_CREDITS);

   // --------------------------------------------------
   // Downstream credit counter
   // --------------------------------------------------
   // Number of instructions the downstream can still accept
   logic [W_CRED-1:0] credit_cnt;

   always_ff @(posedge clk_in) begin
      if (reset) begin
         credit_cnt <= CRED_MAX;
      end else begin
         case ({issue, instr_credit})
            // Send consumes a credit
            2'b10: begin
               credit_cnt <= credit_cnt - 1'b1;
            end
            // Returned credit, saturates at the reset value
            2'b01: begin
               if (credit_cnt != CRED_MAX) begin
                  credit_cnt <= credit_cnt + 1'b1;
               end
            end
            // Send and return cancel out
            default: begin
               credit_cnt <= credit_cnt;
            end
         endcase
      end
   end

   // Gates every issue in the dispatcher
   assign can_send = (credit_cnt != '0);

   // --------------------------------------------------
   // Instruction register
   // --------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (reset) begin
         instr_valid <= 1'b0;
      end else begin
         instr_valid <= issue;
      end
   end

   // Payload only, loaded on issue
   always_ff @(posedge clk_in) begin
      if (issue) begin
         instr <= issue_instr;
      end
   end

endmodule

`default_nettype wire

// File: rtl/pid_dispatch_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "pid_dispatch_config.svh"

module pid_dispatch_top (
   input wire logic clk_in,
   input wire logic reset,
   input wire logic sample_valid,
   input wire pid_dispatch_pkg::sample_t sample,
   output logic sample_credit,
   input wire pid_dispatch_pkg::cfg_wr_t cfg,
   output logic instr_valid,
   output pid_dispatch_pkg::instr_t instr,
   input wire logic instr_credit
);

   import pid_dispatch_pkg::*;

   // --------------------------------------------------
   // Internal nets
   // --------------------------------------------------
   // FIFO head toward the dispatcher
   sample_t head;
   logic head_valid;
   logic pop;

   // Routing table contents
   route_t [`PD_N_CHAN-1:0] src_sel;
   logic [`PD_N_CHAN-1:0] chan_en;

   // Dispatcher toward the output side
   logic issue;
   instr_t issue_instr;
   logic can_send;

   // Input side
   sample_fifo u_sample_fifo (
      .clk_in     (clk_in),
      .reset      (reset),
      .wr_valid   (sample_valid),
      .wr_sample  (sample),
      .pop        (pop),
      .head       (head),
      .head_valid (head_valid),
      .credit     (sample_credit)
   );

   // Processing, routing table and dispatcher
   route_table u_route_table (
      .clk_in  (clk_in),
      .reset   (reset),
      .cfg     (cfg),
      .src_sel (src_sel),
      .chan_en (chan_en)
   );

   instr_dispatch u_instr_dispatch (
      .clk_in      (clk_in),
      .reset       (reset),
      .head        (head),
      .head_valid  (head_valid),
      .src_sel     (src_sel),
      .chan_en     (chan_en),
      .can_send    (can_send),
      .pop         (pop),
      .issue       (issue),
      .issue_instr (issue_instr)
   );

   // Output side
   instr_credit_out u_instr_credit_out (
      .clk_in       (clk_in),
      .reset        (reset),
      .issue        (issue),
      .issue_instr  (issue_instr),
      .instr_credit (instr_credit),
      .can_send     (can_send),
      .instr_valid  (instr_valid),
      .instr        (instr)
   );

endmodule

`default_nettype wire

// File: tb/tb_dispatch_model.svh
`ifndef TB_DISPATCH_MODEL_SVH
`define TB_DISPATCH_MODEL_SVH

// --------------------------------------------------
// Reference model of the routing table
// --------------------------------------------------
// Routes and enables as the DUT should hold them
route_t model_route [`PD_N_CHAN];
logic [`PD_N_CHAN-1:0] model_en;
// Expected instructions in issue order, the monitor reads them by index
instr_t exp_q [$];

// Everything unrouted and disabled, as after reset
function automatic void clear_routes();
   for (int ch = 0; ch < `PD_N_CHAN; ch++) begin
      model_route[ch] = {1'b1, {`PD_W_SRC{1'b0}}};
   end
   model_en = '0;
endfunction

// Only the two known addresses touch the table
function automatic void apply_cfg_write(input cfg_wr_t w);
   if (w.en && w.addr == `PD_CFG_SRC_SEL) begin
      model_route[w.chan] = w.value;
   end else if (w.en && w.addr == `PD_CFG_EN) begin
      model_en[w.chan] = w.value[0];
   end
endfunction

// One instruction per enabled channel on this source, lowest channel first
function automatic void expect_instrs(input sample_t s);
   for (int ch = 0; ch < `PD_N_CHAN; ch++) begin
      if (model_en[ch] && model_route[ch] == {1'b0, s.src}) begin
         exp_q.push_back({chan_t'(ch), s.data});
      end
   end
endfunction

// 32-bit LCG, upper bits returned since the low ones repeat quickly
function automatic logic [23:0] lcg_next(inout logic [31:0] state);
   state = state * 32'd1103515245 + 32'd12345;
   return state[31:8];
endfunction

`endif

// File: tb/tb_pid_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

`include "pid_dispatch_config.svh"

module tb_pid_dispatch;

   import pid_dispatch_pkg::*;

   `include "tb_dispatch_model.svh"

   // 24 + 32 + 16 + 16 + 2*20 + 4*16 samples over all phases
   localparam int N_SAMPLES = 192;
   localparam int WATCHDOG_CYCLES = 200 * N_SAMPLES;
   localparam int HOLD_CYCLES = 300;

   logic clk_in;
   logic reset;
   logic sample_valid;
   sample_t sample;
   logic sample_credit;
   cfg_wr_t cfg;
   logic instr_valid;
   instr_t instr;
   logic instr_credit;

   // Separate generators for stimulus and for the downstream
   logic [31:0] stim_seed = 32'd31;
   logic [31:0] ret_seed = 32'd31;
   // Progress and error counters
   int samples_sent = 0;
   int credits_back = 0;
   int instr_cnt = 0;
   int credits_seen = 0;
   int returned_cnt = 0;
   int exp_rd = 0;
   int mismatch_cnt = 0;
   int protocol_cnt = 0;
   int final_cnt = 0;
   // Downstream withholds credits until this time
   time hold_end = 0;

   pid_dispatch_top u_pid_dispatch_top (
      .clk_in        (clk_in),
      .reset         (reset),
      .sample_valid  (sample_valid),
      .sample        (sample),
      .sample_credit (sample_credit),
      .cfg           (cfg),
      .instr_valid   (instr_valid),
      .instr         (instr),
      .instr_credit  (instr_credit)
   );

   initial begin
      clk_in = 1'b0;
      forever begin
         #20 clk_in = ~clk_in;
      end
   end

   // --------------------------------------------------
   // Output monitor
   // --------------------------------------------------
   always @(posedge clk_in) begin
      if (!reset) begin
         if (sample_credit) begin
            credits_back++;
            assert (credits_back <= samples_sent) else begin
               protocol_cnt++;
               $display("At %0t: sample_credit with no sample outstanding", $time);
            end
         end
         if (instr_credit) begin
            credits_seen++;
         end
         if (instr_valid) begin
            instr_cnt++;
            assert (exp_rd < exp_q.size()) else begin
               protocol_cnt++;
               $display("At %0t: instruction for channel %0d arrived with none expected",
                        $time, instr.chan);
            end
            if (exp_rd < exp_q.size()) begin
               assert (instr == exp_q[exp_rd]) else begin
                  mismatch_cnt++;
                  $display("Mismatch at %0t: instr expected chan %0d data %h, got chan %0d data %h",
                           $time, exp_q[exp_rd].chan, exp_q[exp_rd].data, instr.chan, instr.data);
               end
               exp_rd++;
            end
         end
         // Instructions held downstream never exceed its credits
         assert (instr_cnt - credits_seen <= `PD_OUT_CREDITS) else begin
            protocol_cnt++;
            $display("At %0t: %0d instructions outstanding, more than the downstream credits",
                     $time, instr_cnt - credits_seen);
         end
      end
   end

   // Downstream returns one credit per instruction after a random delay
   initial begin
      logic [23:0] r;
      instr_credit = 1'b0;
      forever begin
         @(negedge clk_in);
         r = lcg_next(ret_seed);
         if (!reset && $time >= hold_end && instr_cnt > returned_cnt && r[9:8] == 2'b00) begin
            instr_credit = 1'b1;
            returned_cnt++;
         end else begin
            instr_credit = 1'b0;
         end
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_in);
      $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("TB FAILED");
      $finish;
   end

   // --------------------------------------------------
   // Stimulus tasks, entered and left on a falling edge
   // --------------------------------------------------
   task automatic write_cfg(input cfg_addr_t addr, input chan_t chan, input route_t value);
      cfg = {1'b1, addr, chan, value};
      apply_cfg_write(cfg);
      @(negedge clk_in);
      cfg = '0;
   endtask

   // Waits for a source credit, the FIFO depth bounds what is in flight
   task automatic send_sample(input src_t src);
      logic [23:0] r;
      while (samples_sent - credits_back >= `PD_FIFO_DEPTH) begin
         sample_valid = 1'b0;
         @(negedge clk_in);
      end
      r = lcg_next(stim_seed);
      sample = {src, r[17:0]};
      sample_valid = 1'b1;
      samples_sent++;
      expect_instrs(sample);
      @(negedge clk_in);
      sample_valid = 1'b0;
   endtask

   // Source 9 or a multiple of 4 half the time, else any source
   task automatic send_mix(input int n);
      logic [23:0] r;
      for (int i = 0; i < n; i++) begin
         r = lcg_next(stim_seed);
         send_sample(r[5] ? src_t'(r[4:0]) : (r[0] ? src_t'(9) : src_t'({r[3:1], 2'b00})));
      end
   endtask

   task automatic wait_drain();
      while (credits_back != samples_sent || exp_rd != exp_q.size()) begin
         @(negedge clk_in);
      end
      @(negedge clk_in);
   endtask

   initial begin
      logic [23:0] r;
      reset = 1'b1;
      sample_valid = 1'b0;
      sample = '0;
      cfg = '0;
      clear_routes();
      repeat (4) @(posedge clk_in);
      @(negedge clk_in);
      reset = 1'b0;

      // Empty table, every sample dropped
      send_mix(24);
      wait_drain();
      // Channel n on source 4n, all enabled
      for (int ch = 0; ch < `PD_N_CHAN; ch++) begin
         write_cfg(`PD_CFG_SRC_SEL, chan_t'(ch), route_t'(4 * ch));
         write_cfg(`PD_CFG_EN, chan_t'(ch), route_t'(1));
      end
      send_mix(32);
      wait_drain();
      // Channels 2, 5 and 7 share source 9
      write_cfg(`PD_CFG_SRC_SEL, 3'd2, 6'd9);
      write_cfg(`PD_CFG_SRC_SEL, 3'd5, 6'd9);
      write_cfg(`PD_CFG_SRC_SEL, 3'd7, 6'd9);
      send_mix(16);
      wait_drain();
      // Channel 5 disabled, then writes to unused addresses
      write_cfg(`PD_CFG_EN, 3'd5, 6'd0);
      write_cfg(4'h0, 3'd0, 6'd9);
      write_cfg(4'h3, 3'd5, 6'd1);
      write_cfg(4'hf, 3'd1, 6'd9);
      send_mix(16);
      wait_drain();

      // Back-pressure, credits withheld while the FIFO fills
      for (int k = 0; k < 2; k++) begin
         hold_end <= $time + HOLD_CYCLES * 40;
         for (int i = 0; i < 20; i++) begin
            send_sample(src_t'(9));
         end
         wait_drain();
      end

      // Full bursts with random reconfiguration in between
      for (int k = 0; k < 4; k++) begin
         for (int w = 0; w < 3; w++) begin
            r = lcg_next(stim_seed);
            write_cfg(r[0] ? `PD_CFG_SRC_SEL : `PD_CFG_EN, chan_t'(r[3:1]),
                      r[4] ? route_t'(6'h20) : route_t'(r[7:5]));
         end
         for (int i = 0; i < `PD_FIFO_DEPTH; i++) begin
            r = lcg_next(stim_seed);
            send_sample(src_t'(r[2:0]));
         end
         wait_drain();
      end

      repeat (20) @(negedge clk_in);
      assert (credits_back == samples_sent) else begin
         final_cnt++;
         $display("Got %0d sample credits for %0d samples", credits_back, samples_sent);
      end
      assert (instr_cnt == exp_q.size()) else begin
         final_cnt++;
         $display("Got %0d instructions for %0d expected", instr_cnt, exp_q.size());
      end
      $display("Errors: %0d mismatch, %0d protocol, %0d final; %0d samples, %0d instructions",
               mismatch_cnt, protocol_cnt, final_cnt, samples_sent, instr_cnt);
      if (mismatch_cnt + protocol_cnt + final_cnt == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: pid_dispatch_top.f
+incdir+rtl
+incdir+tb
rtl/pid_dispatch_pkg.sv
rtl/sample_fifo.sv
rtl/route_table.sv
rtl/instr_dispatch.sv
rtl/instr_credit_out.sv
rtl/pid_dispatch_top.sv
tb/tb_pid_dispatch.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PID dispatch testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
   -f pid_dispatch_top.f --top-module tb_pid_dispatch -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
